// File: include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

`define XLEN 32
`define NREGS 32

`define RESET_PC 32'h0000_0100

// credits held by the instruction source right after reset
`define CORE_CREDITS 2

`endif

// File: hdl/core_pkg.sv
package core_pkg;

	typedef enum logic [6:0] {
		OPCODE_LOAD     = 7'b0000011,
		OPCODE_MISC_MEM = 7'b0001111,
		OPCODE_OP_IMM   = 7'b0010011,
		OPCODE_AUIPC    = 7'b0010111,
		OPCODE_STORE    = 7'b0100011,
		OPCODE_OP       = 7'b0110011,
		OPCODE_LUI      = 7'b0110111,
		OPCODE_BRANCH   = 7'b1100011,
		OPCODE_JALR     = 7'b1100111,
		OPCODE_JAL      = 7'b1101111,
		OPCODE_SYSTEM   = 7'b1110011
	} opcode_e;

	// shared by OP and OP_IMM since both use the same funct3 encoding
	typedef enum logic [2:0] {
		FUNCT3_ALU_ADD_SUB = 3'b000,
		FUNCT3_ALU_SLL     = 3'b001,
		FUNCT3_ALU_SLT     = 3'b010,
		FUNCT3_ALU_SLTU    = 3'b011,
		FUNCT3_ALU_XOR     = 3'b100,
		FUNCT3_ALU_SR      = 3'b101,
		FUNCT3_ALU_OR      = 3'b110,
		FUNCT3_ALU_AND     = 3'b111
	} funct3_alu_e;

	typedef enum logic [2:0] {
		FUNCT3_BRANCH_BEQ  = 3'b000,
		FUNCT3_BRANCH_BNE  = 3'b001,
		FUNCT3_BRANCH_BLT  = 3'b100,
		FUNCT3_BRANCH_BGE  = 3'b101,
		FUNCT3_BRANCH_BLTU = 3'b110,
		FUNCT3_BRANCH_BGEU = 3'b111
	} funct3_branch_e;

	typedef enum logic [3:0] {
		ALU_OP_ADD,
		ALU_OP_SUB,
		ALU_OP_SLL,
		ALU_OP_SLT,
		ALU_OP_SLTU,
		ALU_OP_XOR,
		ALU_OP_SRL,
		ALU_OP_SRA,
		ALU_OP_OR,
		ALU_OP_AND,
		ALU_OP_IN1_PASSTHROUGH
	} alu_op_e;

	typedef enum logic {
		ALU_IN1_SEL_REGFILE_OUT1,
		ALU_IN1_SEL_IMM
	} alu_in1_sel_e;

	typedef enum logic [1:0] {
		ALU_IN2_SEL_REGFILE_OUT2,
		ALU_IN2_SEL_IMM,
		ALU_IN2_SEL_PC
	} alu_in2_sel_e;

	typedef enum logic [2:0] {
		CMP_OP_EQ,
		CMP_OP_NE,
		CMP_OP_LT,
		CMP_OP_GE,
		CMP_OP_LTU,
		CMP_OP_GEU
	} cmp_op_e;

	typedef enum logic [2:0] {
		IMM_FMT_I,
		IMM_FMT_S,
		IMM_FMT_B,
		IMM_FMT_U,
		IMM_FMT_J
	} imm_fmt_e;

	typedef enum logic {
		WR_SEL_ALU_OUT,
		WR_SEL_PC_4
	} wr_sel_e;

endpackage

// File: hdl/decode.sv
`timescale 1ns/1ns

module decode (
	input  logic [31:0]             instr_i,
	output logic                    regfile_we_o,
	output core_pkg::wr_sel_e       wr_sel_o,
	output core_pkg::alu_op_e       alu_op_o,
	output core_pkg::alu_in1_sel_e  alu_in1_sel_o,
	output core_pkg::alu_in2_sel_e  alu_in2_sel_o,
	output core_pkg::imm_fmt_e      imm_fmt_o,
	output core_pkg::cmp_op_e       cmp_op_o,
	output logic                    is_branch_o,
	output logic                    is_jump_o,
	output logic                    illegal_o
);
	import core_pkg::*;

	opcode_e opcode;
	funct3_alu_e funct3_alu;
	funct3_branch_e funct3_branch;

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3_alu = funct3_alu_e'(instr_i[14:12]);
	assign funct3_branch = funct3_branch_e'(instr_i[14:12]);

	always_comb begin
		regfile_we_o = 1'b0;
		wr_sel_o = WR_SEL_ALU_OUT;
		alu_op_o = ALU_OP_ADD;
		alu_in1_sel_o = ALU_IN1_SEL_REGFILE_OUT1;
		alu_in2_sel_o = ALU_IN2_SEL_REGFILE_OUT2;
		imm_fmt_o = IMM_FMT_I;
		cmp_op_o = CMP_OP_EQ;
		is_branch_o = 1'b0;
		is_jump_o = 1'b0;
		illegal_o = 1'b0;

		priority case (opcode)
		OPCODE_LUI: begin
			regfile_we_o = 1'b1;
			alu_op_o = ALU_OP_IN1_PASSTHROUGH;
			alu_in1_sel_o = ALU_IN1_SEL_IMM;
			imm_fmt_o = IMM_FMT_U;
		end
		OPCODE_AUIPC: begin
			regfile_we_o = 1'b1;
			alu_in1_sel_o = ALU_IN1_SEL_IMM;
			alu_in2_sel_o = ALU_IN2_SEL_PC;
			imm_fmt_o = IMM_FMT_U;
		end
		OPCODE_JAL: begin
			regfile_we_o = 1'b1;
			wr_sel_o = WR_SEL_PC_4;
			alu_in1_sel_o = ALU_IN1_SEL_IMM;
			alu_in2_sel_o = ALU_IN2_SEL_PC;
			imm_fmt_o = IMM_FMT_J;
			is_jump_o = 1'b1;
		end
		OPCODE_JALR: begin
			regfile_we_o = 1'b1;
			wr_sel_o = WR_SEL_PC_4;
			alu_in2_sel_o = ALU_IN2_SEL_IMM;
			is_jump_o = 1'b1;
		end
		OPCODE_BRANCH: begin
			// the ALU forms the target while compare_unit decides
			alu_in1_sel_o = ALU_IN1_SEL_IMM;
			alu_in2_sel_o = ALU_IN2_SEL_PC;
			imm_fmt_o = IMM_FMT_B;
			is_branch_o = 1'b1;
			case (funct3_branch)
			FUNCT3_BRANCH_BEQ:  cmp_op_o = CMP_OP_EQ;
			FUNCT3_BRANCH_BNE:  cmp_op_o = CMP_OP_NE;
			FUNCT3_BRANCH_BLT:  cmp_op_o = CMP_OP_LT;
			FUNCT3_BRANCH_BGE:  cmp_op_o = CMP_OP_GE;
			FUNCT3_BRANCH_BLTU: cmp_op_o = CMP_OP_LTU;
			FUNCT3_BRANCH_BGEU: cmp_op_o = CMP_OP_GEU;
			default: begin
				is_branch_o = 1'b0;
				illegal_o = 1'b1;
			end
			endcase
		end
		OPCODE_LOAD: begin
			// address only, there is no data memory behind it
			alu_in2_sel_o = ALU_IN2_SEL_IMM;
		end
		OPCODE_STORE: begin
			alu_in2_sel_o = ALU_IN2_SEL_IMM;
			imm_fmt_o = IMM_FMT_S;
		end
		OPCODE_OP_IMM, OPCODE_OP: begin
			regfile_we_o = 1'b1;
			if (opcode == OPCODE_OP_IMM)
				alu_in2_sel_o = ALU_IN2_SEL_IMM;
			priority case (funct3_alu)
			FUNCT3_ALU_ADD_SUB:
				// only the register form has SUB
				if (opcode == OPCODE_OP && instr_i[30])
					alu_op_o = ALU_OP_SUB;
				else
					alu_op_o = ALU_OP_ADD;
			FUNCT3_ALU_SLL:  alu_op_o = ALU_OP_SLL;
			FUNCT3_ALU_SLT:  alu_op_o = ALU_OP_SLT;
			FUNCT3_ALU_SLTU: alu_op_o = ALU_OP_SLTU;
			FUNCT3_ALU_XOR:  alu_op_o = ALU_OP_XOR;
			FUNCT3_ALU_SR:
				if (instr_i[30])
					alu_op_o = ALU_OP_SRA;
				else
					alu_op_o = ALU_OP_SRL;
			FUNCT3_ALU_OR:   alu_op_o = ALU_OP_OR;
			FUNCT3_ALU_AND:  alu_op_o = ALU_OP_AND;
			endcase
		end
		OPCODE_MISC_MEM, OPCODE_SYSTEM: begin
			// fence, csr access, ecall and ebreak retire with no effect
			regfile_we_o = 1'b0;
		end
		default:
			illegal_o = 1'b1;
		endcase
	end
endmodule

// File: hdl/imm_gen.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module imm_gen (
	input  logic [31:0]         instr_i,
	input  core_pkg::imm_fmt_e  fmt_i,
	output logic [`XLEN-1:0]    imm_o
);
	import core_pkg::*;

	logic sign;

	assign sign = instr_i[31];

	always_comb begin
		case (fmt_i)
		IMM_FMT_S:
			imm_o = {{(`XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
		IMM_FMT_B:
			imm_o = {{(`XLEN-12){sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
		IMM_FMT_U:
			imm_o = {instr_i[31:12], 12'b0};
		IMM_FMT_J:
			imm_o = {{(`XLEN-20){sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
		default:
			imm_o = {{(`XLEN-12){sign}}, instr_i[31:20]};
		endcase
	end
endmodule

// File: hdl/regfile.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module regfile (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [4:0]        rs1_i,
	input  logic [4:0]        rs2_i,
	input  logic [4:0]        rd_i,
	input  logic              we_i,
	input  logic [`XLEN-1:0]  wd_i,
	output logic [`XLEN-1:0]  rs1_data_o,
	output logic [`XLEN-1:0]  rs2_data_o
);
	logic [`XLEN-1:0] regs [`NREGS];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < `NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && rd_i != 5'd0) begin
			regs[rd_i] <= wd_i;
		end
	end

	// x0 reads zero because it is never written after reset
	assign rs1_data_o = regs[rs1_i];
	assign rs2_data_o = regs[rs2_i];

	a_x0_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		((rs1_i != 5'd0) || (rs1_data_o == '0)) && ((rs2_i != 5'd0) || (rs2_data_o == '0)))
		else $error("regfile: x0 read returned a nonzero value");
endmodule

// File: hdl/alu.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module alu (
	input  core_pkg::alu_op_e       op_i,
	input  core_pkg::alu_in1_sel_e  in1_sel_i,
	input  core_pkg::alu_in2_sel_e  in2_sel_i,
	input  logic [`XLEN-1:0]        rs1_data_i,
	input  logic [`XLEN-1:0]        rs2_data_i,
	input  logic [`XLEN-1:0]        imm_i,
	input  logic [`XLEN-1:0]        pc_i,
	output logic [`XLEN-1:0]        result_o
);
	import core_pkg::*;

	logic [`XLEN-1:0] in1;
	logic [`XLEN-1:0] in2;
	logic [$clog2(`XLEN)-1:0] shamt;

	assign in1 = (in1_sel_i == ALU_IN1_SEL_IMM) ? imm_i : rs1_data_i;

	always_comb begin
		case (in2_sel_i)
		ALU_IN2_SEL_IMM: in2 = imm_i;
		ALU_IN2_SEL_PC:  in2 = pc_i;
		default:         in2 = rs2_data_i;
		endcase
	end

	assign shamt = in2[$clog2(`XLEN)-1:0];

	always_comb begin
		case (op_i)
		ALU_OP_SUB:  result_o = in1 - in2;
		ALU_OP_SLL:  result_o = in1 << shamt;
		ALU_OP_SLT:  result_o = {{(`XLEN-1){1'b0}}, $signed(in1) < $signed(in2)};
		ALU_OP_SLTU: result_o = {{(`XLEN-1){1'b0}}, in1 < in2};
		ALU_OP_XOR:  result_o = in1 ^ in2;
		ALU_OP_SRL:  result_o = in1 >> shamt;
		ALU_OP_SRA:  result_o = $signed(in1) >>> shamt;
		ALU_OP_OR:   result_o = in1 | in2;
		ALU_OP_AND:  result_o = in1 & in2;
		ALU_OP_IN1_PASSTHROUGH: result_o = in1;
		default:     result_o = in1 + in2;
		endcase
	end
endmodule

// File: hdl/compare_unit.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module compare_unit (
	input  core_pkg::cmp_op_e  op_i,
	input  logic [`XLEN-1:0]   a_i,
	input  logic [`XLEN-1:0]   b_i,
	output logic               taken_o
);
	import core_pkg::*;

	always_comb begin
		case (op_i)
		CMP_OP_EQ:  taken_o = (a_i == b_i);
		CMP_OP_NE:  taken_o = (a_i != b_i);
		CMP_OP_LT:  taken_o = ($signed(a_i) < $signed(b_i));
		CMP_OP_GE:  taken_o = ($signed(a_i) >= $signed(b_i));
		CMP_OP_LTU: taken_o = (a_i < b_i);
		CMP_OP_GEU: taken_o = (a_i >= b_i);
		default:    taken_o = 1'b0;
		endcase
	end
endmodule

// File: hdl/retire_stage.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module retire_stage (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               instr_valid_i,
	input  logic [4:0]         rd_i,
	input  logic               regfile_we_i,
	input  core_pkg::wr_sel_e  wr_sel_i,
	input  logic [`XLEN-1:0]   alu_result_i,
	input  logic               is_branch_i,
	input  logic               is_jump_i,
	input  logic               cmp_taken_i,
	input  logic               illegal_i,
	output logic [`XLEN-1:0]   pc_o,
	output logic               rf_we_o,
	output logic [`XLEN-1:0]   rf_wd_o,
	output logic               wb_valid_o,
	output logic               wb_we_o,
	output logic [4:0]         wb_rd_o,
	output logic [`XLEN-1:0]   wb_data_o,
	output logic [`XLEN-1:0]   wb_pc_o,
	output logic [`XLEN-1:0]   next_pc_o,
	output logic               taken_o,
	output logic               illegal_trace_o,
	output logic               credit_o
);
	import core_pkg::*;

	logic [`XLEN-1:0] pc_q;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] next_pc;
	logic redirect;
	logic [$clog2(`CORE_CREDITS + 1)-1:0] src_credits;

	assign pc_o = pc_q;
	assign pc_plus4 = pc_q + `XLEN'd4;
	assign redirect = is_jump_i | (is_branch_i & cmp_taken_i);

	// clearing bit 0 matters only for JALR, other targets are already even
	assign next_pc = redirect ? {alu_result_i[`XLEN-1:1], 1'b0} : pc_plus4;

	assign rf_we_o = regfile_we_i & instr_valid_i;
	assign rf_wd_o = (wr_sel_i == WR_SEL_PC_4) ? pc_plus4 : alu_result_i;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= `RESET_PC;
			wb_valid_o <= 1'b0;
			credit_o <= 1'b0;
			wb_we_o <= 1'b0;
			taken_o <= 1'b0;
			illegal_trace_o <= 1'b0;
			src_credits <= `CORE_CREDITS;
		end else begin
			wb_valid_o <= instr_valid_i;
			credit_o <= instr_valid_i;
			wb_we_o <= rf_we_o;
			taken_o <= instr_valid_i & redirect;
			illegal_trace_o <= instr_valid_i & illegal_i;
			// mirrors the credit count held by the source
			src_credits <= src_credits - instr_valid_i + credit_o;
			if (instr_valid_i)
				pc_q <= next_pc;
		end
	end

	always_ff @(posedge clk_i) begin
		if (instr_valid_i) begin
			wb_rd_o <= rd_i;
			wb_data_o <= rf_wd_o;
			wb_pc_o <= pc_q;
			next_pc_o <= next_pc;
		end
	end

	a_credit_with_retire: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		wb_valid_o == credit_o)
		else $error("retire_stage: credit_o and wb_valid_o differ");

	a_target_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		taken_o |-> (next_pc_o[1:0] == 2'b00))
		else $error("retire_stage: taken target is not word aligned");

	// the source must never send without a credit in hand
	a_source_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		instr_valid_i |-> (src_credits != '0))
		else $error("retire_stage: instruction sent with no credit left");
endmodule

// File: hdl/rv_core.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module rv_core (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              instr_valid_i,
	input  logic [31:0]       instr_i,
	output logic              wb_valid_o,
	output logic              wb_we_o,
	output logic [4:0]        wb_rd_o,
	output logic [`XLEN-1:0]  wb_data_o,
	output logic [`XLEN-1:0]  pc_o,
	output logic [`XLEN-1:0]  next_pc_o,
	output logic              taken_o,
	output logic              illegal_o,
	output logic              credit_o
);
	import core_pkg::*;

	logic dec_regfile_we;
	wr_sel_e wr_sel;
	alu_op_e alu_op;
	alu_in1_sel_e alu_in1_sel;
	alu_in2_sel_e alu_in2_sel;
	imm_fmt_e imm_fmt;
	cmp_op_e cmp_op;
	logic is_branch;
	logic is_jump;
	logic dec_illegal;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data;
	logic [`XLEN-1:0] alu_result;
	logic cmp_taken;
	logic [`XLEN-1:0] cur_pc;
	logic rf_we;
	logic [`XLEN-1:0] rf_wd;

	decode i_decode (
		.instr_i       (instr_i),
		.regfile_we_o  (dec_regfile_we),
		.wr_sel_o      (wr_sel),
		.alu_op_o      (alu_op),
		.alu_in1_sel_o (alu_in1_sel),
		.alu_in2_sel_o (alu_in2_sel),
		.imm_fmt_o     (imm_fmt),
		.cmp_op_o      (cmp_op),
		.is_branch_o   (is_branch),
		.is_jump_o     (is_jump),
		.illegal_o     (dec_illegal)
	);

	imm_gen i_imm_gen (
		.instr_i (instr_i),
		.fmt_i   (imm_fmt),
		.imm_o   (imm)
	);

	regfile i_regfile (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.rs1_i      (instr_i[19:15]),
		.rs2_i      (instr_i[24:20]),
		.rd_i       (instr_i[11:7]),
		.we_i       (rf_we),
		.wd_i       (rf_wd),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data)
	);

	alu i_alu (
		.op_i       (alu_op),
		.in1_sel_i  (alu_in1_sel),
		.in2_sel_i  (alu_in2_sel),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.imm_i      (imm),
		.pc_i       (cur_pc),
		.result_o   (alu_result)
	);

	compare_unit i_compare_unit (
		.op_i    (cmp_op),
		.a_i     (rs1_data),
		.b_i     (rs2_data),
		.taken_o (cmp_taken)
	);

	retire_stage i_retire_stage (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.instr_valid_i   (instr_valid_i),
		.rd_i            (instr_i[11:7]),
		.regfile_we_i    (dec_regfile_we),
		.wr_sel_i        (wr_sel),
		.alu_result_i    (alu_result),
		.is_branch_i     (is_branch),
		.is_jump_i       (is_jump),
		.cmp_taken_i     (cmp_taken),
		.illegal_i       (dec_illegal),
		.pc_o            (cur_pc),
		.rf_we_o         (rf_we),
		.rf_wd_o         (rf_wd),
		.wb_valid_o      (wb_valid_o),
		.wb_we_o         (wb_we_o),
		.wb_rd_o         (wb_rd_o),
		.wb_data_o       (wb_data_o),
		.wb_pc_o         (pc_o),
		.next_pc_o       (next_pc_o),
		.taken_o         (taken_o),
		.illegal_trace_o (illegal_o),
		.credit_o        (credit_o)
	);
endmodule

// File: dv/rv_core_tb.sv
`timescale 1ns/1ns
`include "core_defs.svh"

module rv_core_tb;
	import core_pkg::*;

	localparam int WAIT_LIMIT = 50;

	typedef logic [`XLEN-1:0] regs_t [`NREGS];

	typedef struct packed {
		logic              we;
		logic [4:0]        rd;
		logic [`XLEN-1:0]  data;
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  next_pc;
		logic              taken;
		logic              illegal;
		logic [31:0]       cycle;
	} retire_t;

	logic clk_i;
	logic rst_n_i;
	logic instr_valid_i;
	logic [31:0] instr_i;
	logic wb_valid_o;
	logic wb_we_o;
	logic [4:0] wb_rd_o;
	logic [`XLEN-1:0] wb_data_o;
	logic [`XLEN-1:0] pc_o;
	logic [`XLEN-1:0] next_pc_o;
	logic taken_o;
	logic illegal_o;
	logic credit_o;

	integer seed;
	int credits;
	int credits_back;
	int sent;
	int retired;
	int mismatches;
	int failures;
	logic [31:0] cycle;
	regs_t model_regs;
	logic [`XLEN-1:0] model_pc;
	retire_t exp_q [$];

	rv_core i_dut (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.wb_valid_o    (wb_valid_o),
		.wb_we_o       (wb_we_o),
		.wb_rd_o       (wb_rd_o),
		.wb_data_o     (wb_data_o),
		.pc_o          (pc_o),
		.next_pc_o     (next_pc_o),
		.taken_o       (taken_o),
		.illegal_o     (illegal_o),
		.credit_o      (credit_o)
	);

	initial clk_i = 1'b0;
	always #2 clk_i = ~clk_i;

	always @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			cycle <= '0;
		else
			cycle <= cycle + 1;
	end

	task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
			input logic [`XLEN-1:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatches++;
			$display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] exp, input logic [4:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("ERR %0t %s expected x%0d actual x%0d", $time, name, exp, act);
		end
	endtask

	// expected retirement of one instruction under the RV32I rules
	function automatic retire_t exec_ref(input logic [31:0] instr, input regs_t regs,
			input logic [`XLEN-1:0] pc);
		retire_t r;
		logic [`XLEN-1:0] a;
		logic [`XLEN-1:0] b_reg;
		logic [`XLEN-1:0] opnd2;
		logic [`XLEN-1:0] imm_i;
		logic [`XLEN-1:0] imm_b;
		logic [`XLEN-1:0] imm_u;
		logic [`XLEN-1:0] imm_j;
		logic [2:0] f3;
		logic cond;

		f3 = instr[14:12];
		a = regs[instr[19:15]];
		b_reg = regs[instr[24:20]];
		imm_i = {{20{instr[31]}}, instr[31:20]};
		imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		imm_u = {instr[31:12], 12'h000};
		imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		opnd2 = (instr[6:0] == OPCODE_OP) ? b_reg : imm_i;
		cond = 1'b0;
		r = '0;
		r.rd = instr[11:7];
		r.pc = pc;
		r.next_pc = pc + 4;
		case (instr[6:0])
		OPCODE_LUI: begin
			r.we = 1'b1;
			r.data = imm_u;
		end
		OPCODE_AUIPC: begin
			r.we = 1'b1;
			r.data = pc + imm_u;
		end
		OPCODE_JAL, OPCODE_JALR: begin
			r.we = 1'b1;
			r.data = pc + 4;
			r.taken = 1'b1;
			if (instr[6:0] == OPCODE_JAL)
				r.next_pc = pc + imm_j;
			else
				r.next_pc = (a + imm_i) & ~32'h1;
		end
		OPCODE_BRANCH: begin
			case (f3)
			3'd0: cond = (a == b_reg);
			3'd1: cond = (a != b_reg);
			3'd4: cond = ($signed(a) < $signed(b_reg));
			3'd5: cond = ($signed(a) >= $signed(b_reg));
			3'd6: cond = (a < b_reg);
			3'd7: cond = (a >= b_reg);
			default: r.illegal = 1'b1;
			endcase
			if (cond) begin
				r.taken = 1'b1;
				r.next_pc = pc + imm_b;
			end
		end
		OPCODE_OP, OPCODE_OP_IMM: begin
			r.we = 1'b1;
			case (f3)
			3'd0: begin
				if (instr[6:0] == OPCODE_OP && instr[30])
					r.data = a - opnd2;
				else
					r.data = a + opnd2;
			end
			3'd1: r.data = a << opnd2[4:0];
			3'd2: r.data = ($signed(a) < $signed(opnd2)) ? 32'd1 : 32'd0;
			3'd3: r.data = (a < opnd2) ? 32'd1 : 32'd0;
			3'd4: r.data = a ^ opnd2;
			3'd5: begin
				if (instr[30])
					r.data = $signed(a) >>> opnd2[4:0];
				else
					r.data = a >> opnd2[4:0];
			end
			3'd6: r.data = a | opnd2;
			default: r.data = a & opnd2;
			endcase
		end
		OPCODE_LOAD, OPCODE_STORE, OPCODE_MISC_MEM, OPCODE_SYSTEM: begin
			r.we = 1'b0;
		end
		default: r.illegal = 1'b1;
		endcase
		return r;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
			input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPCODE_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPCODE_JAL};
	endfunction

	// random operands stay within x0 to x7 so they keep meeting written values
	function automatic logic [4:0] pick_reg();
		logic [31:0] v;
		v = $random(seed);
		return {2'b00, v[2:0]};
	endfunction

	task automatic tick();
		@(negedge clk_i);
		if (credit_o) begin
			credits++;
			credits_back++;
		end
	endtask

	task automatic send(input logic [31:0] instr);
		int waited;
		retire_t r;
		waited = 0;
		while (credits == 0 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (credits == 0) begin
			failures++;
			$display("no credit came back within %0d cycles, %h was not sent", WAIT_LIMIT, instr);
		end else begin
			r = exec_ref(instr, model_regs, model_pc);
			r.cycle = cycle;
			exp_q.push_back(r);
			if (r.we && r.rd != 5'd0)
				model_regs[r.rd] = r.data;
			model_pc = r.next_pc;
			credits--;
			sent++;
			instr_i = instr;
			instr_valid_i = 1'b1;
			tick();
			instr_valid_i = 1'b0;
		end
	endtask

	// LUI then ADDI with the upper part corrected for the sign of the low part
	task automatic load_reg(input logic [4:0] rd, input logic [31:0] value);
		send(enc_u(value[31:12] + value[11], rd, OPCODE_LUI));
		send(enc_i(value[11:0], rd, 3'd0, rd, OPCODE_OP_IMM));
	endtask

	always @(negedge clk_i) begin : compare_retire
		retire_t r;
		if (rst_n_i && exp_q.size() != 0 && exp_q[0].cycle + 1 < cycle) begin
			failures++;
			$display("instruction accepted in cycle %0d never retired", exp_q[0].cycle);
			void'(exp_q.pop_front());
		end
		if (rst_n_i && wb_valid_o) begin
			if (exp_q.size() == 0) begin
				failures++;
				$display("retirement at %0t with no instruction outstanding", $time);
			end else begin
				r = exp_q.pop_front();
				retired++;
				if (cycle != r.cycle + 1) begin
					failures++;
					$display("instruction sent in cycle %0d retired in cycle %0d", r.cycle, cycle);
				end
				// the credit comes back in the same cycle as the retirement
				check_bit("credit_o", 1'b1, credit_o);
				check_word("pc_o", r.pc, pc_o);
				check_word("next_pc_o", r.next_pc, next_pc_o);
				check_bit("wb_we_o", r.we, wb_we_o);
				check_reg("wb_rd_o", r.rd, wb_rd_o);
				if (r.we)
					check_word("wb_data_o", r.data, wb_data_o);
				check_bit("taken_o", r.taken, taken_o);
				check_bit("illegal_o", r.illegal, illegal_o);
			end
		end
	end

	initial begin
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		logic alt;
		int br_off;
		int waited;
		logic [2:0] br_f3 [6];

		seed = 32'h72ea_f844;
		rst_n_i = 1'b0;
		instr_valid_i = 1'b0;
		instr_i = '0;
		credits = `CORE_CREDITS;
		credits_back = 0;
		sent = 0;
		retired = 0;
		mismatches = 0;
		failures = 0;
		model_pc = `RESET_PC;
		for (int i = 0; i < `NREGS; i++)
			model_regs[i] = '0;
		br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

		repeat (2) @(posedge clk_i);
		@(negedge clk_i);
		rst_n_i = 1'b1;
		tick();
		check_bit("wb_valid_o", 1'b0, wb_valid_o);
		check_bit("credit_o", 1'b0, credit_o);
		check_bit("wb_we_o", 1'b0, wb_we_o);
		check_bit("taken_o", 1'b0, taken_o);
		check_bit("illegal_o", 1'b0, illegal_o);

		// arithmetic with a negative operand and then writes aimed at x0
		load_reg(5'd1, 32'h8765_4321);
		load_reg(5'd2, 32'h0000_0009);
		send(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd3, OPCODE_OP));
		send(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd4, OPCODE_OP));
		send(enc_i(12'h407, 5'd1, 3'd5, 5'd5, OPCODE_OP_IMM));
		send(enc_i(12'h055, 5'd0, 3'd0, 5'd0, OPCODE_OP_IMM));
		send(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd6, OPCODE_OP));
		for (int k = 1; k < 8; k++)
			load_reg(k[4:0], $random(seed));
		for (int n = 0; n < 40; n++) begin
			rd = pick_reg();
			rs1 = pick_reg();
			rs2 = pick_reg();
			f3 = $random(seed);
			alt = $random(seed);
			imm = $random(seed);
			if (n % 2 == 0) begin
				if (f3 == 3'd1)
					imm = {7'b0, imm[4:0]};
				else if (f3 == 3'd5)
					imm = {1'b0, alt, 5'b0, imm[4:0]};
				send(enc_i(imm, rs1, f3, rd, OPCODE_OP_IMM));
			end else begin
				send(enc_r((f3 == 3'd0 || f3 == 3'd5) ? {1'b0, alt, 5'b0} : 7'b0,
					rs2, rs1, f3, rd, OPCODE_OP));
			end
		end

		send(enc_u(20'habcde, 5'd8, OPCODE_LUI));
		send(enc_u(20'h00123, 5'd9, OPCODE_AUIPC));
		send(enc_j(21'h000100, 5'd1));
		send(enc_j(21'h1fffc0, 5'd2));
		load_reg(5'd5, 32'h0001_2040);
		// odd offset so the target has bit 0 set before it is cleared
		send(enc_i(12'd13, 5'd5, 3'd0, 5'd1, OPCODE_JALR));

		for (int n = 0; n < 24; n++) begin
			load_reg(5'd10, $random(seed));
			if (n % 4 == 0)
				send(enc_r(7'h00, 5'd0, 5'd10, 3'd0, 5'd11, OPCODE_OP));
			else
				load_reg(5'd11, $random(seed));
			br_off = ($random(seed) % 512) * 4;
			send(enc_b(br_off[12:0], 5'd11, 5'd10, br_f3[n % 6]));
		end

		// store, fence, ecall, load and an undefined opcode
		send(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd4, OPCODE_STORE));
		send(32'h0ff0_000f);
		send(32'h0000_0073);
		send(enc_i(12'h010, 5'd1, 3'd2, 5'd3, OPCODE_LOAD));
		send(32'h0000_00ff);

		for (int n = 0; n < 12; n++)
			send(enc_i($random(seed), pick_reg(), 3'd0, pick_reg(), OPCODE_OP_IMM));
		repeat (4)
			tick();
		for (int n = 0; n < 6; n++)
			send(enc_i($random(seed), pick_reg(), 3'd4, pick_reg(), OPCODE_OP_IMM));

		waited = 0;
		while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
			tick();
			waited++;
		end
		if (exp_q.size() != 0) begin
			failures++;
			$display("%0d instructions were still waiting to retire at the end", exp_q.size());
		end
		tick();
		if (credits != `CORE_CREDITS) begin
			failures++;
			$display("source holds %0d credits at the end instead of %0d", credits, `CORE_CREDITS);
		end
		if (retired != sent || credits_back != sent) begin
			failures++;
			$display("%0d sent but %0d retired and %0d credits returned", sent, retired,
				credits_back);
		end

		$display("summary: %0d sent, %0d retired, %0d value errors, %0d other errors",
			sent, retired, mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end
endmodule

// File: filelist.f
+incdir+include
hdl/core_pkg.sv
hdl/decode.sv
hdl/imm_gen.sv
hdl/regfile.sv
hdl/alu.sv
hdl/compare_unit.sv
hdl/retire_stage.sv
hdl/rv_core.sv
dv/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - hdl/core_pkg.sv
  - hdl/decode.sv
  - hdl/imm_gen.sv
  - hdl/regfile.sv
  - hdl/alu.sv
  - hdl/compare_unit.sv
  - hdl/retire_stage.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_tb.sv
